// ==== math_pkg.sv ====
package math_pkg;

    // Signed Q16.16 fixed point, the format of all view-space and screen values.
    typedef logic signed [31:0] q16_16_t;

    // Full-width product of two Q16.16 values, Q32.32.
    typedef logic signed [63:0] q32_32_t;

    localparam int FRAC_BITS = 16;

    // One half in the fraction of a Q32.32 product that is shifted back by FRAC_BITS.
    // Adding it before the shift rounds to nearest.
    localparam q32_32_t ROUND_HALF = q32_32_t'(1) << (FRAC_BITS - 1);

endpackage

// ==== geometry_pkg.sv ====
package geometry_pkg;

    typedef struct packed {
        math_pkg::q16_16_t x;
        math_pkg::q16_16_t y;
        math_pkg::q16_16_t z;
    } vec3_t;

    typedef struct packed {
        vec3_t       pos;
        logic [15:0] color;
    } vertex_t;

    // 3 x 112 bits, v0 in the upper bits of the packed word.
    typedef struct packed {
        vertex_t v0;
        vertex_t v1;
        vertex_t v2;
    } triangle_t;

    // One bit per view-volume plane, set when the vertex lies outside it.
    typedef logic [4:0] outcode_t;

    localparam int SCREEN_WIDTH  = 320;
    localparam int SCREEN_HEIGHT = 240;

    // View units that map onto half the screen height.
    localparam int VIEW_SCALE = 200;

    // Pixels per view unit in Q16.16, truncated (39321).
    localparam int SCALE_FACTOR = ((SCREEN_HEIGHT / 2) << math_pkg::FRAC_BITS) / VIEW_SCALE;

    // Horizontal half extent of the view volume keeps the screen aspect ratio.
    localparam math_pkg::q16_16_t X_LIMIT = math_pkg::q16_16_t'(
        (longint'(VIEW_SCALE) * (SCREEN_WIDTH / 2) << math_pkg::FRAC_BITS)
        / (SCREEN_HEIGHT / 2));
    localparam math_pkg::q16_16_t Y_LIMIT =
        math_pkg::q16_16_t'(longint'(VIEW_SCALE) << math_pkg::FRAC_BITS);
    localparam math_pkg::q16_16_t NEAR_Z =
        math_pkg::q16_16_t'(longint'(1) << math_pkg::FRAC_BITS);

    localparam int OC_LEFT   = 0;
    localparam int OC_RIGHT  = 1;
    localparam int OC_BOTTOM = 2;
    localparam int OC_TOP    = 3;
    localparam int OC_NEAR   = 4;

endpackage

// ==== screen_normalizer.sv ====
`timescale 1ns/1ps

module screen_normalizer (
    input  logic                   clk,
    input  logic                   rst,

    input  geometry_pkg::triangle_t triangle,
    input  logic                   in_valid,
    output logic                   in_ready,

    output geometry_pkg::triangle_t out_triangle,
    output logic                   out_valid,
    input  logic                   out_ready,

    output logic                   busy
);

    // Scales a view-space coordinate to pixels and rounds to nearest.
    // The operand arrives already widened so that negating it cannot overflow.
    function automatic math_pkg::q16_16_t scale_round(input math_pkg::q32_32_t v);
        math_pkg::q32_32_t prod;
        prod = v * math_pkg::q32_32_t'(geometry_pkg::SCALE_FACTOR);
        return math_pkg::q16_16_t'((prod + math_pkg::ROUND_HALF) >>> math_pkg::FRAC_BITS);
    endfunction

    function automatic geometry_pkg::vertex_t norm_vertex(input geometry_pkg::vertex_t vin);
        geometry_pkg::vertex_t vout;
        vout = vin;
        vout.pos.x = scale_round(math_pkg::q32_32_t'(vin.pos.x))
                   + math_pkg::q16_16_t'((geometry_pkg::SCREEN_WIDTH / 2)
                                         << math_pkg::FRAC_BITS);
        // Screen y grows downward, so view y is mirrored.
        vout.pos.y = scale_round(-math_pkg::q32_32_t'(vin.pos.y))
                   + math_pkg::q16_16_t'((geometry_pkg::SCREEN_HEIGHT / 2)
                                         << math_pkg::FRAC_BITS);
        return vout;
    endfunction

    geometry_pkg::triangle_t triangle_q;
    logic                    valid_q;

    assign in_ready     = !valid_q || out_ready;
    assign out_valid    = valid_q;
    assign out_triangle = triangle_q;
    assign busy         = valid_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (in_ready) begin
            valid_q <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            triangle_q.v0 <= norm_vertex(triangle.v0);
            triangle_q.v1 <= norm_vertex(triangle.v1);
            triangle_q.v2 <= norm_vertex(triangle.v2);
        end
    end

endmodule

// ==== clip_classifier.sv ====
`timescale 1ns/1ps

module clip_classifier (
    input  logic                   clk,
    input  logic                   rst,

    input  geometry_pkg::triangle_t triangle,
    input  logic                   in_valid,
    output logic                   in_ready,

    output logic [14:0]            outcodes,
    output logic                   out_valid,
    input  logic                   out_ready,

    output logic                   busy
);

    // Compares one view-space vertex against the five planes of the view volume.
    // All compares are signed Q16.16.
    function automatic geometry_pkg::outcode_t classify(input geometry_pkg::vertex_t v);
        geometry_pkg::outcode_t oc;
        oc = '0;
        oc[geometry_pkg::OC_LEFT]   = v.pos.x < -geometry_pkg::X_LIMIT;
        oc[geometry_pkg::OC_RIGHT]  = v.pos.x >  geometry_pkg::X_LIMIT;
        oc[geometry_pkg::OC_BOTTOM] = v.pos.y < -geometry_pkg::Y_LIMIT;
        oc[geometry_pkg::OC_TOP]    = v.pos.y >  geometry_pkg::Y_LIMIT;
        oc[geometry_pkg::OC_NEAR]   = v.pos.z <  geometry_pkg::NEAR_Z;
        return oc;
    endfunction

    geometry_pkg::outcode_t oc0;
    geometry_pkg::outcode_t oc1;
    geometry_pkg::outcode_t oc2;
    logic [14:0]            outcodes_q;
    logic                   valid_q;

    assign oc0 = classify(triangle.v0);
    assign oc1 = classify(triangle.v1);
    assign oc2 = classify(triangle.v2);

    assign in_ready  = !valid_q || out_ready;
    assign out_valid = valid_q;
    assign outcodes  = outcodes_q;
    assign busy      = valid_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (in_ready) begin
            valid_q <= in_valid;
        end
    end

    // Vertex 0 sits in the low five bits.
    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            outcodes_q <= {oc2, oc1, oc0};
        end
    end

endmodule

// ==== triangle_culler.sv ====
`timescale 1ns/1ps

module triangle_culler (
    input  logic                   clk,
    input  logic                   rst,

    input  geometry_pkg::triangle_t norm_triangle,
    input  logic                   norm_valid,
    input  logic [14:0]            outcodes,
    input  logic                   code_valid,
    output logic                   in_ready,

    output geometry_pkg::triangle_t out_triangle,
    output logic                   out_clip,
    output logic                   out_valid,
    input  logic                   out_ready,

    output logic                   busy,
    output logic [15:0]            culled_count
);

    geometry_pkg::outcode_t oc0;
    geometry_pkg::outcode_t oc1;
    geometry_pkg::outcode_t oc2;
    logic                   consume;
    logic                   cull;
    logic                   clip;

    geometry_pkg::triangle_t triangle_q;
    logic                    clip_q;
    logic                    valid_q;
    logic [15:0]             culled_q;

    assign oc0 = outcodes[4:0];
    assign oc1 = outcodes[9:5];
    assign oc2 = outcodes[14:10];

    // A plane that all three vertices lie outside hides the whole triangle.
    assign cull = |(oc0 & oc1 & oc2);
    // Some vertex is outside, but the triangle may still reach the screen.
    assign clip = |(oc0 | oc1 | oc2);

    // The two stages run in lockstep, so both valids rise in the same cycle.
    assign in_ready = !valid_q || out_ready;
    assign consume  = norm_valid && code_valid && in_ready;

    assign out_triangle = triangle_q;
    assign out_clip     = clip_q;
    assign out_valid    = valid_q;
    assign busy         = valid_q;
    assign culled_count = culled_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q  <= 1'b0;
            culled_q <= '0;
        end else begin
            if (in_ready) begin
                valid_q <= consume && !cull;
            end
            if (consume && cull) begin
                culled_q <= culled_q + 16'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (consume && !cull) begin
            triangle_q <= norm_triangle;
            clip_q     <= clip;
        end
    end

endmodule

// ==== screen_stage.sv ====
`timescale 1ns/1ps

module screen_stage (
    input  logic                   clk,
    input  logic                   rst,

    input  geometry_pkg::triangle_t triangle,
    input  logic                   in_valid,
    output logic                   in_ready,

    output geometry_pkg::triangle_t out_triangle,
    output logic                   out_clip,
    output logic                   out_valid,
    input  logic                   out_ready,

    output logic                   busy,
    output logic [15:0]            culled_count
);

    logic                    norm_in_ready;
    logic                    code_in_ready;
    geometry_pkg::triangle_t norm_triangle;
    logic                    norm_valid;
    logic                    norm_busy;
    logic [14:0]             outcodes;
    logic                    code_valid;
    logic                    code_busy;
    logic                    join_ready;
    logic                    cull_busy;

    // Each branch takes the triangle only when the other branch takes it too.
    assign in_ready = norm_in_ready && code_in_ready;
    assign busy     = norm_busy || code_busy || cull_busy;

    screen_normalizer i_screen_normalizer (
        .clk          (clk),
        .rst          (rst),
        .triangle     (triangle),
        .in_valid     (in_valid && code_in_ready),
        .in_ready     (norm_in_ready),
        .out_triangle (norm_triangle),
        .out_valid    (norm_valid),
        .out_ready    (join_ready),
        .busy         (norm_busy)
    );

    clip_classifier i_clip_classifier (
        .clk       (clk),
        .rst       (rst),
        .triangle  (triangle),
        .in_valid  (in_valid && norm_in_ready),
        .in_ready  (code_in_ready),
        .outcodes  (outcodes),
        .out_valid (code_valid),
        .out_ready (join_ready),
        .busy      (code_busy)
    );

    triangle_culler i_triangle_culler (
        .clk           (clk),
        .rst           (rst),
        .norm_triangle (norm_triangle),
        .norm_valid    (norm_valid),
        .outcodes      (outcodes),
        .code_valid    (code_valid),
        .in_ready      (join_ready),
        .out_triangle  (out_triangle),
        .out_clip      (out_clip),
        .out_valid     (out_valid),
        .out_ready     (out_ready),
        .busy          (cull_busy),
        .culled_count  (culled_count)
    );

endmodule

// ==== tb_screen_stage.sv ====
`timescale 1ns/1ps

module tb_screen_stage;

    localparam int N_TRI          = 400;
    localparam int BURST_LEN      = 32;
    localparam int TIMEOUT_CYCLES = N_TRI * 8 + 200;

    typedef logic [335:0] value_t;

    logic                    clk;
    logic                    rst;
    geometry_pkg::triangle_t triangle;
    logic                    in_valid;
    logic                    in_ready;
    geometry_pkg::triangle_t out_triangle;
    logic                    out_clip;
    logic                    out_valid;
    logic                    out_ready;
    logic                    busy;
    logic [15:0]             culled_count;

    logic [15:0]             lfsr_state;
    int                      mismatches;
    int                      failures;
    int                      issued;
    int                      accepted;
    int                      sample_idx;
    int                      cycle_count;
    logic                    accept_now;
    logic                    in_burst;
    logic                    done;
    logic [15:0]             exp_culled;
    logic                    stalled;
    geometry_pkg::triangle_t held_triangle;
    logic                    held_clip;

    // Scoreboard of kept triangles, in input order.
    geometry_pkg::triangle_t exp_tri_q[$];
    logic                    exp_clip_q[$];
    int                      exp_idx_q[$];
    logic                    exp_timed_q[$];

    screen_stage i_screen_stage (
        .clk          (clk),
        .rst          (rst),
        .triangle     (triangle),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .out_triangle (out_triangle),
        .out_clip     (out_clip),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .busy         (busy),
        .culled_count (culled_count)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Polynomial x^16 + x^15 + x^13 + x^4 + 1.
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[14] ^ s[12] ^ s[3]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    // Range 0 and 1 stay well inside, 2 straddles the limit, 3 lies far beyond it.
    function automatic math_pkg::q16_16_t rand_coord(input logic [1:0] range, input logic neg,
                                                      input int limit);
        int mag;
        case (range)
            2'd2:    mag = limit - 512 + int'(rand_bits(10));
            2'd3:    mag = limit + 1 + int'(rand_bits(24));
            default: mag = int'(rand_bits(23));
        endcase
        return neg ? -mag : mag;
    endfunction

    // The code holds range and sign for x, y and z; z is measured from the near plane.
    function automatic geometry_pkg::vertex_t make_vertex(input logic [8:0] tmpl,
                                                          input logic fresh,
                                                          input logic inside_only);
        geometry_pkg::vertex_t v;
        logic [8:0]            c;
        c = fresh ? 9'(rand_bits(9)) : tmpl;
        if (inside_only) begin
            c = {2'd0, c[6], 2'd0, c[3], 3'd0};
        end
        v.pos.x = rand_coord(c[8:7], c[6], geometry_pkg::X_LIMIT);
        v.pos.y = rand_coord(c[5:4], c[3], geometry_pkg::Y_LIMIT);
        v.pos.z = geometry_pkg::NEAR_Z + rand_coord(c[2:1], c[0], 0);
        v.color = 16'(rand_bits(16));
        return v;
    endfunction

    // Shared codes put all three vertices in the same region, which makes culls common.
    function automatic geometry_pkg::triangle_t make_triangle(input logic inside_only);
        geometry_pkg::triangle_t t;
        logic [8:0]              tmpl;
        logic                    shared;
        shared = 1'(rand_bits(1));
        tmpl   = 9'(rand_bits(9));
        t.v0 = make_vertex(tmpl, !shared, inside_only);
        t.v1 = make_vertex(tmpl, !shared, inside_only);
        t.v2 = make_vertex(tmpl, !shared, inside_only);
        return t;
    endfunction

    function automatic math_pkg::q16_16_t to_pixel(input longint view, input int center);
        longint scaled;
        scaled = view * longint'(geometry_pkg::SCALE_FACTOR) + longint'(math_pkg::ROUND_HALF);
        return math_pkg::q16_16_t'(scaled >>> math_pkg::FRAC_BITS)
             + math_pkg::q16_16_t'(center << math_pkg::FRAC_BITS);
    endfunction

    function automatic geometry_pkg::vertex_t expect_vertex(input geometry_pkg::vertex_t v);
        geometry_pkg::vertex_t e;
        e = v;
        e.pos.x = to_pixel(longint'($signed(v.pos.x)), geometry_pkg::SCREEN_WIDTH / 2);
        e.pos.y = to_pixel(-longint'($signed(v.pos.y)), geometry_pkg::SCREEN_HEIGHT / 2);
        return e;
    endfunction

    function automatic geometry_pkg::outcode_t outcode_of(input geometry_pkg::vertex_t v);
        geometry_pkg::outcode_t oc;
        longint                 x;
        longint                 y;
        longint                 z;
        x  = longint'($signed(v.pos.x));
        y  = longint'($signed(v.pos.y));
        z  = longint'($signed(v.pos.z));
        oc = '0;
        if (x < -longint'(geometry_pkg::X_LIMIT)) oc[geometry_pkg::OC_LEFT] = 1'b1;
        if (x > longint'(geometry_pkg::X_LIMIT)) oc[geometry_pkg::OC_RIGHT] = 1'b1;
        if (y < -longint'(geometry_pkg::Y_LIMIT)) oc[geometry_pkg::OC_BOTTOM] = 1'b1;
        if (y > longint'(geometry_pkg::Y_LIMIT)) oc[geometry_pkg::OC_TOP] = 1'b1;
        if (z < longint'(geometry_pkg::NEAR_Z)) oc[geometry_pkg::OC_NEAR] = 1'b1;
        return oc;
    endfunction

    task automatic check_value(input string name, input value_t got, input value_t exp);
        if (got !== exp) begin
            mismatches++;
            $display("FAIL %0t %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    // Runs at the falling edge, where every handshake signal is settled for the next edge.
    task automatic monitor_cycle();
        geometry_pkg::triangle_t want;
        geometry_pkg::outcode_t  oc0;
        geometry_pkg::outcode_t  oc1;
        geometry_pkg::outcode_t  oc2;
        int                      idx;
        logic                    timed;
        sample_idx++;
        // A triangle taken at the last edge or waiting at the output keeps the pipeline busy.
        if (accept_now || out_valid) begin
            check_value("busy", value_t'(busy), value_t'(1'b1));
        end
        accept_now = in_valid && in_ready;
        if (in_burst && in_valid) begin
            check_value("in_ready", value_t'(in_ready), value_t'(1'b1));
        end
        if (accept_now) begin
            accepted++;
            oc0 = outcode_of(triangle.v0);
            oc1 = outcode_of(triangle.v1);
            oc2 = outcode_of(triangle.v2);
            if ((oc0 & oc1 & oc2) != 5'd0) begin
                exp_culled = exp_culled + 16'd1;
            end else begin
                want.v0 = expect_vertex(triangle.v0);
                want.v1 = expect_vertex(triangle.v1);
                want.v2 = expect_vertex(triangle.v2);
                exp_tri_q.push_back(want);
                exp_clip_q.push_back((oc0 | oc1 | oc2) != 5'd0);
                exp_idx_q.push_back(sample_idx);
                exp_timed_q.push_back(in_burst);
            end
        end
        if (stalled) begin
            check_value("out_valid", value_t'(out_valid), value_t'(1'b1));
            check_value("out_triangle", value_t'(out_triangle), value_t'(held_triangle));
            check_value("out_clip", value_t'(out_clip), value_t'(held_clip));
        end
        if (out_valid && out_ready) begin
            if (exp_tri_q.size() == 0) begin
                failures++;
                $display("Output triangle at %0t arrived with nothing left to expect", $time);
            end else begin
                check_value("out_triangle", value_t'(out_triangle),
                            value_t'(exp_tri_q.pop_front()));
                check_value("out_clip", value_t'(out_clip), value_t'(exp_clip_q.pop_front()));
                idx   = exp_idx_q.pop_front();
                timed = exp_timed_q.pop_front();
                if (timed) begin
                    check_value("latency", value_t'(sample_idx - idx), value_t'(2));
                end
            end
        end
        stalled       = out_valid && !out_ready;
        held_triangle = out_triangle;
        held_clip     = out_clip;
    endtask

    initial begin
        rst        = 1'b1;
        in_valid   = 1'b0;
        out_ready  = 1'b0;
        triangle   = '0;
        lfsr_state = 16'd39;
        mismatches = 0;
        failures   = 0;
        issued     = 0;
        accepted   = 0;
        sample_idx = 0;
        accept_now = 1'b0;
        in_burst   = 1'b0;
        exp_culled = '0;
        stalled    = 1'b0;
        done       = 1'b0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_value("out_valid", value_t'(out_valid), value_t'(1'b0));
        check_value("busy", value_t'(busy), value_t'(1'b0));
        check_value("in_ready", value_t'(in_ready), value_t'(1'b1));
        check_value("culled_count", value_t'(culled_count), value_t'(16'd0));
        while (!done) begin
            monitor_cycle();
            done = accepted == N_TRI && !accept_now && !busy && exp_tri_q.size() == 0;
            if (!done) begin
                @(posedge clk);
                if (issued == N_TRI) begin
                    if (accept_now) begin
                        in_valid <= 1'b0;
                    end
                end else if (!in_valid || accept_now) begin
                    if (issued >= N_TRI - BURST_LEN) begin
                        in_burst = 1'b1;
                    end
                    if (in_burst || rand_bits(2) != 32'd0) begin
                        in_valid <= 1'b1;
                        triangle <= make_triangle(in_burst);
                        issued++;
                    end else begin
                        in_valid <= 1'b0;
                    end
                end
                if (in_burst) begin
                    out_ready <= 1'b1;
                end else begin
                    out_ready <= 1'(rand_bits(1));
                end
                @(negedge clk);
            end
        end
        check_value("culled_count", value_t'(culled_count), value_t'(exp_culled));
        $display("Checks done: %0d value mismatches, %0d other errors", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout after %0d cycles with %0d of %0d triangles accepted", cycle_count,
                 accepted, N_TRI);
        $display("Checks done: %0d value mismatches, %0d other errors", mismatches, failures);
        $display(">>> FAIL");
        $finish;
    end

endmodule

// ==== screen_stage.f ====
math_pkg.sv
geometry_pkg.sv
screen_normalizer.sv
clip_classifier.sv
triangle_culler.sv
screen_stage.sv
tb_screen_stage.sv

// ==== Makefile ====
# Verilator flow for the screen-mapping stage.
# Any variable below can be overridden on the command line.

VERILATOR ?= verilator
TOP       ?= tb_screen_stage
RTL_TOP   ?= screen_stage
FILELIST  ?= screen_stage.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= >>> PASS
VFLAGS    ?=

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only --timing $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

sim: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qxF '$(PASS_MSG)' $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
